// File: build.f
logic/bus_map_pkg.sv
logic/board_ctrl_pkg.sv
logic/clock_enables.sv
logic/io_decoder.sv
logic/cpu_io_registers.sv
logic/sound_link.sv
logic/vblank_irq.sv
logic/main_board.sv
testbench/tb_clock.sv
testbench/main_board_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := main_board_tb
RTL_TOP    := main_board
FILELIST   := build.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/main_board_tb.sv
`timescale 1ns/1ps

module main_board_tb;

	logic                            clk_49m;
	logic                            reset;
	logic                            pause;
	logic                            vblank;
	bus_map_pkg::cpu_bus_t           bus;
	board_ctrl_pkg::player_in_t      p1;
	board_ctrl_pkg::player_in_t      p2;
	logic [7:0]                      controls_dip;
	logic [7:0]                      ext_data;
	logic [7:0]                      cpu_din;
	bus_map_pkg::mem_region_e        region;
	logic [3:0]                      rom_bank;
	board_ctrl_pkg::latch_t          latch;
	board_ctrl_pkg::sound_o_t        sound;
	logic                            irq_n;
	logic                            cpu_e;
	logic                            cpu_q;

	int          error_count;
	int          check_count;
	int          timeout_count;
	logic [31:0] lcg_state;

	tb_clock clock_gen_i (
		.clk_o   (clk_49m),
		.reset_o (reset)
	);

	main_board dut_i (
		.clk_49m        (clk_49m),
		.reset          (reset),
		.pause_i        (pause),
		.vblank_i       (vblank),
		.bus_i          (bus),
		.p1_i           (p1),
		.p2_i           (p2),
		.controls_dip_i (controls_dip),
		.ext_data_i     (ext_data),
		.cpu_din_o      (cpu_din),
		.region_o       (region),
		.rom_bank_o     (rom_bank),
		.latch_o        (latch),
		.sound_o        (sound),
		.irq_n_o        (irq_n),
		.cpu_e_o        (cpu_e),
		.cpu_q_o        (cpu_q)
	);

	// ==============================
	// Helpers
	// ==============================

	// Numerical Recipes LCG where the middle byte has the best spread
	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("ERROR at %0d ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Every call leaves the time 2 ns after a rising edge so inputs can be driven
	task automatic idle_clocks(input int n);
		repeat (n) @(posedge clk_49m);
		#2;
	endtask

	// Reset is looked at on the falling edge so the DUT's reset state can be checked
	task automatic wait_reset_release();
		int k;
		k = 0;
		@(negedge clk_49m);
		while (!reset && k < 10) begin
			@(negedge clk_49m);
			k++;
		end
		if (!reset) begin
			timeout_count++;
			$display("Timeout at %0d ns: reset was never released", $time);
		end
	endtask

	// Write cycle held for 16 clocks so one cen_3m always lands inside it
	task automatic hold_write(input logic [15:0] addr, input logic [7:0] data);
		idle_clocks(1);
		bus = {addr, data, 1'b0};
		idle_clocks(16);
	endtask

	task automatic release_bus();
		bus = {16'h0000, 8'h00, 1'b1};
	endtask

	task automatic write_bus(input logic [15:0] addr, input logic [7:0] data);
		hold_write(addr, data);
		release_bus();
	endtask

	// Read data is combinational and is checked a few ns after the address
	task automatic read_expect(input logic [15:0] addr, input logic [7:0] exp, input string name);
		idle_clocks(1);
		bus = {addr, 8'h00, 1'b1};
		#5;
		check_byte(name, cpu_din, exp);
	endtask

	// Long enough for vblank_irq to see both levels on cen_6m
	task automatic pulse_vblank();
		idle_clocks(1);
		vblank = 1'b1;
		idle_clocks(12);
		vblank = 1'b0;
		idle_clocks(12);
	endtask

	task automatic wait_irq_level(input logic level, input string what);
		int k;
		k = 0;
		while (irq_n !== level && k < 40) begin
			idle_clocks(1);
			k++;
		end
		if (irq_n !== level) begin
			timeout_count++;
			$display("Timeout at %0d ns: irq_n_o never went to %b %s", $time, level, what);
		end
	endtask

	// Counts clocks from the end of the write until the stretched pulse drops
	task automatic measure_stretch(input logic use_irq, input string name);
		int   clocks;
		logic level;
		clocks = 0;
		level  = 1'b1;
		while (level && clocks < 40) begin
			idle_clocks(1);
			clocks++;
			level = use_irq ? sound.irq_trigger : sound.cmd_strobe;
		end
		if (level) begin
			timeout_count++;
			$display("Timeout at %0d ns: %s stayed high for 40 clocks after the write",
				$time, name);
		end else begin
			check_count++;
			assert (clocks >= 16 && clocks <= 20) else begin
				error_count++;
				$display("ERROR at %0d ns: %s high for %0d clocks, expected 16 to 20",
					$time, name, clocks);
			end
		end
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic reset_and_clocks();
		logic exp_e;
		logic exp_q;
		check_bit("irq_n_o", irq_n, 1'b1);
		check_bit("sound_o.cmd_strobe", sound.cmd_strobe, 1'b0);
		check_bit("sound_o.irq_trigger", sound.irq_trigger, 1'b0);
		check_byte("latch_o", {3'b000, latch}, 8'h00);
		check_byte("rom_bank_o", {4'h0, rom_bank}, 8'h00);
		check_bit("cpu_e_o", cpu_e, 1'b0);
		check_bit("cpu_q_o", cpu_q, 1'b0);
		// The k-th edge out of reset is the one where the divider holds count k
		// E is high for counts 0 to 7 and Q for counts 4 to 11
		for (int k = 0; k < 32; k++) begin
			idle_clocks(1);
			exp_e = (k % 16) < 8;
			exp_q = (k % 16) >= 4 && (k % 16) < 12;
			check_bit("cpu_e_o", cpu_e, exp_e);
			check_bit("cpu_q_o", cpu_q, exp_q);
		end
		// Six more edges reach count 5 where E and Q are both high
		idle_clocks(6);
		check_bit("cpu_e_o", cpu_e, 1'b1);
		check_bit("cpu_q_o", cpu_q, 1'b1);
		// While paused both clocks stay high past the counts where they would fall
		pause = 1'b1;
		for (int k = 0; k < 20; k++) begin
			idle_clocks(1);
			check_bit("cpu_e_o paused", cpu_e, 1'b1);
			check_bit("cpu_q_o paused", cpu_q, 1'b1);
		end
		pause = 1'b0;
	endtask

	task automatic decode_and_read_mux();
		logic [7:0] rnd;
		logic [6:0] p1_bits;
		logic [6:0] p2_bits;
		idle_clocks(1);
		rnd          = lcg_next();
		p1_bits      = rnd[6:0];
		rnd          = lcg_next();
		p2_bits      = rnd[6:0];
		p1           = p1_bits;
		p2           = p2_bits;
		controls_dip = lcg_next();
		ext_data     = lcg_next();
		// Player bytes read back active low under a fixed high bit 7
		read_expect(16'h81A0, {1'b1, ~p1_bits}, "cpu_din_o IN1");
		read_expect(16'h81C0, {1'b1, ~p2_bits}, "cpu_din_o IN2");
		read_expect(16'h8160, controls_dip, "cpu_din_o DSW2");
		read_expect(16'h8180, controls_dip, "cpu_din_o IN0");
		read_expect(16'h81E0, controls_dip, "cpu_din_o DSW1");
		read_expect(16'h8120, 8'hFF, "cpu_din_o watchdog");
		read_expect(16'h1234, ext_data, "cpu_din_o video RAM");
		check_byte("region_o", {5'b0, region}, {5'b0, bus_map_pkg::region_videoram});
		read_expect(16'h8900, ext_data, "cpu_din_o work RAM");
		check_byte("region_o", {5'b0, region}, {5'b0, bus_map_pkg::region_workram});
		read_expect(16'h9000, ext_data, "cpu_din_o bank ROM");
		check_byte("region_o", {5'b0, region}, {5'b0, bus_map_pkg::region_bankrom});
		read_expect(16'hB000, ext_data, "cpu_din_o main ROM");
		check_byte("region_o", {5'b0, region}, {5'b0, bus_map_pkg::region_mainrom});
		// Unused hole in the I/O page floats high
		read_expect(16'h8400, 8'hFF, "cpu_din_o open bus");
		check_byte("region_o", {5'b0, region}, {5'b0, bus_map_pkg::region_none});
		release_bus();
	endtask

	task automatic register_writes();
		logic [7:0]             pal [16];
		logic [7:0]             scroll_val;
		logic [7:0]             bank_val;
		logic [7:0]             rnd;
		logic                   v;
		board_ctrl_pkg::latch_t exp_latch;
		for (int i = 0; i < 16; i++) begin
			pal[i] = lcg_next();
			write_bus(16'h8000 | 16'(i), pal[i]);
		end
		for (int i = 0; i < 16; i++) begin
			read_expect(16'h8000 | 16'(i), pal[i], "cpu_din_o palette");
		end
		release_bus();
		scroll_val = lcg_next();
		write_bus(16'h8100, scroll_val);
		read_expect(16'h8100, scroll_val, "cpu_din_o scroll");
		release_bus();
		bank_val = lcg_next();
		write_bus(16'h8300, bank_val);
		check_byte("rom_bank_o", {4'h0, rom_bank}, {4'h0, bank_val[3:0]});
		// Set every latch address and then clear them with junk in the upper data bits
		exp_latch = '0;
		for (int pass = 0; pass < 2; pass++) begin
			v = (pass == 0);
			for (int idx = 0; idx < 8; idx++) begin
				rnd = lcg_next();
				write_bus(16'h8200 | 16'(idx), {rnd[7:1], v});
				case (idx)
					0: exp_latch.irq_enable = v;
					4: exp_latch.stars_enable = v;
					5: exp_latch.sound_mute = v;
					6: exp_latch.flip_x = v;
					7: exp_latch.flip_y = v;
					default: begin
					end
				endcase
				check_byte("latch_o", {3'b000, latch}, {3'b000, exp_latch});
			end
		end
	endtask

	task automatic sound_link_pulses();
		logic [7:0]  rnd;
		logic [15:0] in_addr [6];
		logic        exp_ctl;
		rnd = lcg_next();
		hold_write(16'h8700, rnd);
		check_bit("sound_o.cmd_strobe", sound.cmd_strobe, 1'b1);
		check_byte("sound_o.data", sound.data, rnd);
		release_bus();
		measure_stretch(1'b0, "sound_o.cmd_strobe");
		// The command byte outlives the strobe
		check_byte("sound_o.data", sound.data, rnd);
		hold_write(16'h8600, lcg_next());
		check_bit("sound_o.irq_trigger", sound.irq_trigger, 1'b1);
		release_bus();
		measure_stretch(1'b1, "sound_o.irq_trigger");
		in_addr[0] = 16'h8160;
		in_addr[1] = 16'h8180;
		in_addr[2] = 16'h81A0;
		in_addr[3] = 16'h81C0;
		in_addr[4] = 16'h81E0;
		in_addr[5] = 16'h8400;
		for (int j = 0; j < 6; j++) begin
			idle_clocks(1);
			bus = {in_addr[j], 8'h00, 1'b1};
			#5;
			exp_ctl = (in_addr[j] == 16'h8180) || (in_addr[j] == 16'h81A0) ||
				(in_addr[j] == 16'h81C0) || (in_addr[j] == 16'h81E0);
			check_bit("sound_o.cs_controls_dip1", sound.cs_controls_dip1, exp_ctl);
			check_bit("sound_o.cs_dip2", sound.cs_dip2, in_addr[j] == 16'h8160);
			// Sound board sees CPU A6 on its A5 and CPU A5 on its A6
			check_bit("sound_o.a5", sound.a5, in_addr[j][6]);
			check_bit("sound_o.a6", sound.a6, in_addr[j][5]);
		end
		release_bus();
	endtask

	task automatic vblank_interrupts();
		write_bus(16'h8200, 8'h01);
		check_bit("irq_n_o", irq_n, 1'b1);
		for (int n = 0; n < 4; n++) begin
			pulse_vblank();
			if (n % 2 == 0) begin
				wait_irq_level(1'b0, "after an odd vblank");
			end else begin
				check_bit("irq_n_o even vblank", irq_n, 1'b1);
			end
			// Acknowledge by dropping the enable and then arm again
			write_bus(16'h8200, 8'h00);
			wait_irq_level(1'b1, "after the enable was cleared");
			write_bus(16'h8200, 8'h01);
		end
		write_bus(16'h8200, 8'h00);
		for (int n = 0; n < 2; n++) begin
			pulse_vblank();
			check_bit("irq_n_o disabled", irq_n, 1'b1);
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		error_count   = 0;
		check_count   = 0;
		timeout_count = 0;
		lcg_state     = 32'hbaf6;
		pause         = 1'b0;
		vblank        = 1'b0;
		bus           = {16'h0000, 8'h00, 1'b1};
		p1            = '0;
		p2            = '0;
		controls_dip  = 8'h00;
		ext_data      = 8'h00;

		wait_reset_release();
		reset_and_clocks();
		decode_and_read_mux();
		register_writes();
		sound_link_pulses();
		vblank_interrupts();

		$display("Summary: %0d checks, %0d errors, %0d timeouts",
			check_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o,
	output logic reset_o
);

	// 25 MHz stand-in for the 49.152 MHz master clock, 40 ns period
	initial begin
		clk_o = 1'b0;
		forever begin
			#20 clk_o = ~clk_o;
		end
	end

	// Active low reset held over the first two rising edges
	// Release comes 2 ns after the edge like every other input
	initial begin
		reset_o = 1'b0;
		repeat (2) @(posedge clk_o);
		#2 reset_o = 1'b1;
	end

endmodule

// File: logic/main_board.sv
`timescale 1ns/1ps

module main_board (
	input  logic                              clk_49m,
	input  logic                              reset,
	input  logic                              pause_i,
	input  logic                              vblank_i,
	input  bus_map_pkg::cpu_bus_t             bus_i,
	input  board_ctrl_pkg::player_in_t        p1_i,
	input  board_ctrl_pkg::player_in_t        p2_i,
	input  logic [7:0]                        controls_dip_i,
	input  logic [7:0]                        ext_data_i,
	output logic [7:0]                        cpu_din_o,
	output bus_map_pkg::mem_region_e          region_o,
	output logic [$clog2(bus_map_pkg::bank_count)-1:0] rom_bank_o,
	output board_ctrl_pkg::latch_t            latch_o,
	output board_ctrl_pkg::sound_o_t          sound_o,
	output logic                              irq_n_o,
	output logic                              cpu_e_o,
	output logic                              cpu_q_o
);

	logic                 cen_6m;
	logic                 cen_3m;
	bus_map_pkg::io_sel_t sel;

	// ==============================
	// Clocking
	// ==============================

	clock_enables clk_en_i (
		.clk_49m  (clk_49m),
		.reset    (reset),
		.pause_i  (pause_i),
		.cen_6m_o (cen_6m),
		.cen_3m_o (cen_3m),
		.cpu_e_o  (cpu_e_o),
		.cpu_q_o  (cpu_q_o)
	);

	// ==============================
	// CPU side
	// ==============================

	io_decoder decoder_i (
		.bus_i    (bus_i),
		.sel_o    (sel),
		.region_o (region_o)
	);

	cpu_io_registers regs_i (
		.clk_49m        (clk_49m),
		.reset          (reset),
		.cen_6m_i       (cen_6m),
		.cen_3m_i       (cen_3m),
		.bus_i          (bus_i),
		.sel_i          (sel),
		.region_i       (region_o),
		.p1_i           (p1_i),
		.p2_i           (p2_i),
		.controls_dip_i (controls_dip_i),
		.ext_data_i     (ext_data_i),
		.cpu_din_o      (cpu_din_o),
		.latch_o        (latch_o),
		.rom_bank_o     (rom_bank_o)
	);

	// Command and IRQ lines toward the sound board
	sound_link sound_i (
		.clk_49m (clk_49m),
		.reset   (reset),
		.bus_i   (bus_i),
		.sel_i   (sel),
		.sound_o (sound_o)
	);

	vblank_irq irq_i (
		.clk_49m      (clk_49m),
		.reset        (reset),
		.cen_6m_i     (cen_6m),
		.vblank_i     (vblank_i),
		.irq_enable_i (latch_o.irq_enable),
		.irq_n_o      (irq_n_o)
	);

endmodule

// File: logic/vblank_irq.sv
`timescale 1ns/1ps

module vblank_irq (
	input  logic clk_49m,
	input  logic reset,
	input  logic cen_6m_i,
	input  logic vblank_i,
	input  logic irq_enable_i,
	output logic irq_n_o
);

	logic vblank_q;
	logic phase;

	// The game expects one interrupt every other frame
	// phase flips on each vblank edge and the IRQ fires while it was clear
	// Once asserted, the IRQ stays low until the enable is written to 0
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			vblank_q <= 1'b0;
			phase    <= 1'b0;
			irq_n_o  <= 1'b1;
		end else if (cen_6m_i) begin
			vblank_q <= vblank_i;
			if (!irq_enable_i) begin
				// Acknowledge is done by clearing the enable bit
				irq_n_o <= 1'b1;
			end else if (vblank_i && !vblank_q) begin
				phase <= ~phase;
				if (!phase) begin
					irq_n_o <= 1'b0;
				end
			end
		end
	end

endmodule

// File: logic/sound_link.sv
`timescale 1ns/1ps

module sound_link (
	input  logic                    clk_49m,
	input  logic                    reset,
	input  bus_map_pkg::cpu_bus_t   bus_i,
	input  bus_map_pkg::io_sel_t    sel_i,
	output board_ctrl_pkg::sound_o_t sound_o
);

	logic [7:0] cmd_data;
	// Index 0 is the command strobe, index 1 the sound IRQ trigger
	logic [1:0] trig;
	logic [1:0] pulse;
	logic [3:0] hold [2];

	assign trig = {sel_i.soundon_wr, sel_i.soundcmd_wr};

	// The CPU drops its data a cycle after the write
	// The latch keeps the last byte for the slower sound board
	always_ff @(posedge clk_49m) begin
		if (sel_i.soundcmd_wr) begin
			cmd_data <= bus_i.data;
		end
	end

	// ==============================
	// Pulse stretchers
	// ==============================

	// Each trigger reloads its hold count, so a fresh write restarts the stretch
	// The pulse only falls once the count has run down to zero
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			pulse <= '0;
			for (int i = 0; i < 2; i++) begin
				hold[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (trig[i]) begin
					pulse[i] <= 1'b1;
					hold[i]  <= board_ctrl_pkg::stretch_hold;
				end else if (hold[i] != '0) begin
					hold[i] <= hold[i] - 4'd1;
				end else begin
					pulse[i] <= 1'b0;
				end
			end
		end
	end

	// Sound board selects and address lines
	// A5 and A6 are crossed so the sound board's input mux lands on P1 at 0x81A0
	// and on P2 at 0x81C0
	always_comb begin
		sound_o.data             = cmd_data;
		sound_o.cmd_strobe       = pulse[0];
		sound_o.irq_trigger      = pulse[1];
		sound_o.cs_controls_dip1 = sel_i.in0 | sel_i.in1 | sel_i.in2 | sel_i.dsw1;
		sound_o.cs_dip2          = sel_i.dsw2;
		sound_o.a5               = bus_i.addr[6];
		sound_o.a6               = bus_i.addr[5];
	end

endmodule

// File: logic/cpu_io_registers.sv
`timescale 1ns/1ps

module cpu_io_registers (
	input  logic                              clk_49m,
	input  logic                              reset,
	input  logic                              cen_6m_i,
	input  logic                              cen_3m_i,
	input  bus_map_pkg::cpu_bus_t             bus_i,
	input  bus_map_pkg::io_sel_t              sel_i,
	input  bus_map_pkg::mem_region_e          region_i,
	input  board_ctrl_pkg::player_in_t        p1_i,
	input  board_ctrl_pkg::player_in_t        p2_i,
	input  logic [7:0]                        controls_dip_i,
	input  logic [7:0]                        ext_data_i,
	output logic [7:0]                        cpu_din_o,
	output board_ctrl_pkg::latch_t            latch_o,
	output logic [$clog2(bus_map_pkg::bank_count)-1:0] rom_bank_o
);

	logic [7:0] palette_mem [bus_map_pkg::palette_entries];
	logic [$clog2(bus_map_pkg::palette_entries)-1:0] pal_idx;
	logic [7:0] scroll_q;

	assign pal_idx = bus_i.addr[$clog2(bus_map_pkg::palette_entries)-1:0];

	// Player port byte as the CPU sees it
	// Bit 7 is tied high and the controls read back active low
	function automatic logic [7:0] player_byte(input board_ctrl_pkg::player_in_t p);
		return {1'b1, ~p.fire, ~p.joy};
	endfunction

	// ==============================
	// Write-side registers
	// ==============================

	// Palette file, written on any clock
	always_ff @(posedge clk_49m) begin
		if (sel_i.palette_wr) begin
			palette_mem[pal_idx] <= bus_i.data;
		end
	end

	// Scroll byte only moves on the pixel clock enable
	always_ff @(posedge clk_49m) begin
		if (cen_6m_i && sel_i.scroll_wr) begin
			scroll_q <= bus_i.data;
		end
	end

	// ROM bank picks one of the nine graphics ROMs from the low data bits
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			rom_bank_o <= '0;
		end else if (cen_3m_i && sel_i.bank_wr) begin
			rom_bank_o <= bus_i.data[$clog2(bus_map_pkg::bank_count)-1:0];
		end
	end

	// Main latch behaves like an LS259
	// A[2:0] picks the output and D0 is the value stored
	// Outputs 1 to 3 drive coin counters and are not modelled
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			latch_o <= '0;
		end else if (cen_3m_i && sel_i.latch_wr) begin
			case (bus_i.addr[2:0])
				3'd0: latch_o.irq_enable <= bus_i.data[0];
				3'd4: latch_o.stars_enable <= bus_i.data[0];
				3'd5: latch_o.sound_mute <= bus_i.data[0];
				3'd6: latch_o.flip_x <= bus_i.data[0];
				3'd7: latch_o.flip_y <= bus_i.data[0];
				default: begin
				end
			endcase
		end
	end

	// ==============================
	// CPU read multiplexer
	// ==============================

	// I/O windows come first since they overlap no memory region
	always_comb begin
		if (sel_i.palette) begin
			cpu_din_o = palette_mem[pal_idx];
		end else if (sel_i.scroll) begin
			cpu_din_o = scroll_q;
		end else if (sel_i.watchdog) begin
			// Watchdog reset location reads as all ones
			cpu_din_o = bus_map_pkg::open_bus_data;
		end else if (sel_i.in1) begin
			cpu_din_o = player_byte(p1_i);
		end else if (sel_i.in2) begin
			cpu_din_o = player_byte(p2_i);
		end else if (sel_i.dsw2 | sel_i.in0 | sel_i.dsw1) begin
			// Coins and DIP switches are muxed on the sound board
			cpu_din_o = controls_dip_i;
		end else begin
			case (region_i)
				bus_map_pkg::region_workram,
				bus_map_pkg::region_bankrom,
				bus_map_pkg::region_mainrom,
				bus_map_pkg::region_videoram: cpu_din_o = ext_data_i;
				default: cpu_din_o = bus_map_pkg::open_bus_data;
			endcase
		end
	end

endmodule

// File: logic/io_decoder.sv
`timescale 1ns/1ps

module io_decoder (
	input  bus_map_pkg::cpu_bus_t    bus_i,
	output bus_map_pkg::io_sel_t     sel_o,
	output bus_map_pkg::mem_region_e region_o
);

	logic        wr;
	logic [11:0] tag16;
	logic [12:0] tag8;
	logic [7:0]  page;

	assign wr    = ~bus_i.rnw;
	assign tag16 = bus_i.addr[15:4];
	assign tag8  = bus_i.addr[15:3];
	assign page  = bus_i.addr[15:8];

	// ==============================
	// I/O selects in 0x8000-0x87FF
	// ==============================

	always_comb begin
		// Readable windows, direction left open
		sel_o.palette  = (tag16 == bus_map_pkg::tag_palette);
		sel_o.scroll   = (tag16 == bus_map_pkg::tag_scroll);
		sel_o.watchdog = (tag16 == bus_map_pkg::tag_watchdog);
		sel_o.dsw2     = (tag16 == bus_map_pkg::tag_dsw2);
		sel_o.in0      = (tag16 == bus_map_pkg::tag_in0);
		sel_o.in1      = (tag16 == bus_map_pkg::tag_in1);
		sel_o.in2      = (tag16 == bus_map_pkg::tag_in2);
		sel_o.dsw1     = (tag16 == bus_map_pkg::tag_dsw1);

		// Write strobes
		sel_o.latch_wr    = (tag8 == bus_map_pkg::tag_latch) & wr;
		sel_o.bank_wr     = (page == bus_map_pkg::tag_bank) & wr;
		sel_o.soundon_wr  = (page == bus_map_pkg::tag_soundon) & wr;
		sel_o.soundcmd_wr = (page == bus_map_pkg::tag_soundcmd) & wr;
		sel_o.scroll_wr   = sel_o.scroll & wr;
		sel_o.palette_wr  = sel_o.palette & wr;
	end

	// ==============================
	// Memory regions
	// ==============================

	// The I/O page at 0x8000-0x87FF falls through to region_none
	always_comb begin
		if (!bus_i.addr[15]) begin
			// 32KB video RAM at 0x0000-0x7FFF
			region_o = bus_map_pkg::region_videoram;
		end else if (bus_i.addr[15:11] == 5'b10001) begin
			// 2KB work RAM at 0x8800-0x8FFF
			region_o = bus_map_pkg::region_workram;
		end else if (bus_i.addr[15:12] == 4'h9) begin
			// Banked graphics ROM window at 0x9000-0x9FFF
			region_o = bus_map_pkg::region_bankrom;
		end else if (bus_i.addr[15:13] >= 3'b101) begin
			// Program ROM covers 0xA000-0xFFFF
			region_o = bus_map_pkg::region_mainrom;
		end else begin
			region_o = bus_map_pkg::region_none;
		end
	end

endmodule

// File: logic/clock_enables.sv
`timescale 1ns/1ps

module clock_enables (
	input  logic clk_49m,
	input  logic reset,
	input  logic pause_i,
	output logic cen_6m_o,
	output logic cen_3m_o,
	output logic cpu_e_o,
	output logic cpu_q_o
);

	logic [board_ctrl_pkg::div_width-1:0] div;

	// Free-running divider of the 49.152 MHz master clock
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			div <= '0;
		end else begin
			div <= div + 1'b1;
		end
	end

	// 6.144 MHz enable fires when the low three bits wrap
	assign cen_6m_o = (div[board_ctrl_pkg::div_width-2:0] == '0);
	// 3.072 MHz enable fires once per full divider cycle
	assign cen_3m_o = (div == '0);

	// E and Q for the MC6809E, one full cycle every 16 master clocks
	// Q trails E by a quarter period, i.e. 4 clocks
	// Pausing freezes both, which stalls the CPU mid-cycle
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			cpu_e_o <= 1'b0;
			cpu_q_o <= 1'b0;
		end else if (!pause_i) begin
			case (div)
				4'd0:  cpu_e_o <= 1'b1;
				4'd4:  cpu_q_o <= 1'b1;
				4'd8:  cpu_e_o <= 1'b0;
				4'd12: cpu_q_o <= 1'b0;
				default: begin
				end
			endcase
		end
	end

endmodule

// File: logic/board_ctrl_pkg.sv
package board_ctrl_pkg;

	// Hold count for stretched pulses to the sound board
	// The sound board samples on cen_3m, once every 16 clocks
	localparam logic [3:0] stretch_hold = 4'd15;

	// Width of the master clock divider
	localparam int div_width = 4;

	// ==============================
	// Control-side types
	// ==============================

	// Outputs of the LS259 main latch that the board actually uses
	typedef struct packed {
		logic irq_enable;
		logic stars_enable;
		logic sound_mute;
		logic flip_x;
		logic flip_y;
	} latch_t;

	// Player controls, active high
	// fire is {bomb, right, left} and joy is {down, up, right, left}
	typedef struct packed {
		logic [2:0] fire;
		logic [3:0] joy;
	} player_in_t;

	// Everything that crosses over to the sound board
	typedef struct packed {
		logic [7:0] data;
		logic       cmd_strobe;
		logic       irq_trigger;
		logic       cs_controls_dip1;
		logic       cs_dip2;
		logic       a5;
		logic       a6;
	} sound_o_t;

endpackage

// File: logic/bus_map_pkg.sv
package bus_map_pkg;

	// ==============================
	// Address map constants
	// ==============================

	// I/O page tags, compared against addr[15:4]
	localparam logic [11:0] tag_palette  = 12'h800;
	localparam logic [11:0] tag_scroll   = 12'h810;
	localparam logic [11:0] tag_watchdog = 12'h812;
	localparam logic [11:0] tag_dsw2     = 12'h816;
	localparam logic [11:0] tag_in0      = 12'h818;
	localparam logic [11:0] tag_in1      = 12'h81A;
	localparam logic [11:0] tag_in2      = 12'h81C;
	localparam logic [11:0] tag_dsw1     = 12'h81E;

	// The main latch spans 0x8200-0x8207, so only addr[15:3] is compared
	localparam logic [12:0] tag_latch = 13'h1040;

	// Write-only pages, compared against addr[15:8]
	localparam logic [7:0] tag_bank     = 8'h83;
	localparam logic [7:0] tag_soundon  = 8'h86;
	localparam logic [7:0] tag_soundcmd = 8'h87;

	// Value seen by the CPU when nothing drives the data bus
	localparam logic [7:0] open_bus_data = 8'hFF;
	localparam int palette_entries = 16;
	// Nine 4KB graphics banks sit behind the 0x9000 window
	localparam int bank_count = 9;

	// ==============================
	// Bus and decode types
	// ==============================

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        rnw;
	} cpu_bus_t;

	typedef enum logic [2:0] {
		region_none,
		region_videoram,
		region_workram,
		region_bankrom,
		region_mainrom
	} mem_region_e;

	// Selects ending in _wr are already qualified with the write direction
	typedef struct packed {
		logic palette;
		logic scroll;
		logic watchdog;
		logic dsw2;
		logic in0;
		logic in1;
		logic in2;
		logic dsw1;
		logic latch_wr;
		logic bank_wr;
		logic soundon_wr;
		logic soundcmd_wr;
		logic scroll_wr;
		logic palette_wr;
	} io_sel_t;

endpackage
